// File: sv32_pkg.sv
// Sv32 address, page table entry and exception cause definitions.
// Shared by the MMU datapath and its testbench, referenced by scoped name.
package sv32_pkg;

  // basic widths
  localparam int XLEN_W        = 32;
  localparam int VADDR_W       = 32;
  localparam int PADDR_W       = 34;
  localparam int PPN_W         = 22;
  localparam int VPN_W         = 20;
  localparam int PAGE_OFFSET_W = 12;
  // one VPN field per level, PPN starts above the flag byte and RSW
  localparam int VPN_PART_W    = 10;
  localparam int PTE_PPN_LSB   = 10;
  // entries are 4 bytes
  localparam int PTE_SIZE_LOG2 = 2;

  typedef logic [VADDR_W-1:0] vaddr_t;
  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [PPN_W-1:0]   ppn_t;
  typedef logic [VPN_W-1:0]   vpn_t;
  typedef logic [XLEN_W-1:0]  pte_t;

  // pte flag bit positions
  localparam int PTE_V = 0;
  localparam int PTE_R = 1;
  localparam int PTE_W = 2;
  localparam int PTE_X = 3;
  localparam int PTE_U = 4;
  localparam int PTE_A = 6;
  localparam int PTE_D = 7;

  typedef logic [1:0] priv_t;
  localparam priv_t PRIV_U = 2'b00;
  localparam priv_t PRIV_S = 2'b01;

  // exception causes raised by the data side
  typedef logic [3:0] cause_t;
  localparam cause_t CAUSE_LD_ACCESS = 4'd5;
  localparam cause_t CAUSE_ST_ACCESS = 4'd7;
  localparam cause_t CAUSE_LD_PAGE   = 4'd13;
  localparam cause_t CAUSE_ST_PAGE   = 4'd15;

endpackage

// File: mmu_pkg.sv
// Sizing and state encodings of this data MMU.
// Used by the TLB, the page table walker and the translation stage.
package mmu_pkg;

  // ------------------------------------------------------------------
  // data TLB
  // ------------------------------------------------------------------
  // fully associative, replaced round robin
  localparam int TLB_ENTRIES = 4;

  // selects one TLB entry, also the width of the victim pointer
  typedef logic [$clog2(TLB_ENTRIES)-1:0] tlb_idx_t;

  // ------------------------------------------------------------------
  // page table walker
  // ------------------------------------------------------------------
  typedef enum logic [2:0] {
    // waiting for a miss from the translation stage
    IDLE,
    // wishbone read of the root level entry
    READ_L1,
    // wishbone read of the leaf level entry
    READ_L0,
    // one cycle refill pulse towards the TLB
    UPDATE,
    // one cycle fault pulse towards the translation stage
    FAULT
  } ptw_state_e;

endpackage

// File: tlb_update_if.sv
// Refill path from the page table walker into the data TLB.
// A one cycle valid pulse writes the entry under the victim pointer.
`timescale 1ns/1ps

interface tlb_update_if;

  logic           valid;
  sv32_pkg::vpn_t vpn;
  sv32_pkg::pte_t pte;
  // leaf was found at level 1
  logic           is_mega;

  modport walker (output valid, vpn, pte, is_mega);
  modport tlb    (input  valid, vpn, pte, is_mega);

endinterface

// File: walk_if.sv
// Handshake between the translation stage and the page table walker.
// start is only taken while busy is low, faults pulse once at the end.
`timescale 1ns/1ps

interface walk_if;

  logic             start;
  sv32_pkg::vaddr_t vaddr;
  logic             busy;
  // end of a failed walk, one cycle each
  logic             page_fault;
  logic             access_fault;

  modport requester (
    output start, vaddr,
    input  busy, page_fault, access_fault
  );
  modport walker (
    input  start, vaddr,
    output busy, page_fault, access_fault
  );

endinterface

// File: dtlb.sv
// Four entry fully associative data TLB for Sv32.
// Combinational lookup on the VPN, refill from the walker, full flush.
`timescale 1ns/1ps

module dtlb (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           flush_i,
  input  sv32_pkg::vpn_t lookup_vpn_i,
  output logic           hit_o,
  output sv32_pkg::pte_t pte_o,
  output logic           is_mega_o,
  tlb_update_if.tlb      upd
);

  // entry storage
  logic              valid_q [mmu_pkg::TLB_ENTRIES];
  sv32_pkg::vpn_t    vpn_q   [mmu_pkg::TLB_ENTRIES];
  sv32_pkg::pte_t    pte_q   [mmu_pkg::TLB_ENTRIES];
  logic              mega_q  [mmu_pkg::TLB_ENTRIES];
  // next entry to be replaced
  mmu_pkg::tlb_idx_t victim_q;

  logic [mmu_pkg::TLB_ENTRIES-1:0] match;

  // ------------------------------------------------------------------
  // lookup
  // ------------------------------------------------------------------
  // megapage entries only compare VPN[1]
  always_comb begin
    for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
      if (mega_q[i]) begin
        match[i] = valid_q[i] &&
                   (vpn_q[i][sv32_pkg::VPN_W-1 -: sv32_pkg::VPN_PART_W] ==
                    lookup_vpn_i[sv32_pkg::VPN_W-1 -: sv32_pkg::VPN_PART_W]);
      end else begin
        match[i] = valid_q[i] && (vpn_q[i] == lookup_vpn_i);
      end
    end
  end

  assign hit_o = |match;

  // at most one entry matches, refills only happen on a miss
  always_comb begin
    pte_o     = '0;
    is_mega_o = 1'b0;
    for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
      if (match[i]) begin
        pte_o     = pte_q[i];
        is_mega_o = mega_q[i];
      end
    end
  end

  // ------------------------------------------------------------------
  // refill and flush
  // ------------------------------------------------------------------
  // flush wins over a refill in the same cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
        valid_q[i] <= 1'b0;
      end
      victim_q <= '0;
    end else if (flush_i) begin
      for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (upd.valid) begin
      valid_q[victim_q] <= 1'b1;
      // round robin, wraps around
      victim_q <= victim_q + 1'b1;
    end
  end

  // tag and content of the refilled entry
  always_ff @(posedge clk_i) begin
    if (upd.valid) begin
      vpn_q[victim_q]  <= upd.vpn;
      pte_q[victim_q]  <= upd.pte;
      mega_q[victim_q] <= upd.is_mega;
    end
  end

endmodule

// File: ptw.sv
// Sv32 hardware page table walker with a read only Wishbone classic master.
// Started by the translation stage on a TLB miss, ends with a TLB refill
// pulse or with a page or access fault pulse.
`timescale 1ns/1ps

module ptw (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             flush_i,
  input  sv32_pkg::ppn_t   satp_ppn_i,
  walk_if.walker           walk,
  tlb_update_if.walker     upd,
  output logic             wb_cyc_o,
  output logic             wb_stb_o,
  output sv32_pkg::paddr_t wb_adr_o,
  input  sv32_pkg::pte_t   wb_dat_i,
  input  logic             wb_ack_i,
  input  logic             wb_err_i
);

  mmu_pkg::ptw_state_e state_q, state_d;
  sv32_pkg::vaddr_t    vaddr_q;
  sv32_pkg::pte_t      pte_q;
  // level bit, set when the leaf was found at level 1
  logic                mega_q, mega_d;
  logic                acc_err_q, acc_err_d;
  // a flush hit this walk, its result must not reach the TLB
  logic                flushed_q;

  logic                pte_inv;
  logic                pte_leaf;
  logic                mega_misaligned;
  logic                lvl1;
  sv32_pkg::ppn_t      base_ppn;
  logic [sv32_pkg::VPN_PART_W-1:0] vpn_part;

  // ------------------------------------------------------------------
  // decode of the word on the bus
  // ------------------------------------------------------------------
  // V clear or W without R is reserved
  assign pte_inv  = !wb_dat_i[sv32_pkg::PTE_V] ||
                    (wb_dat_i[sv32_pkg::PTE_W] && !wb_dat_i[sv32_pkg::PTE_R]);
  assign pte_leaf = wb_dat_i[sv32_pkg::PTE_R] || wb_dat_i[sv32_pkg::PTE_X];
  // a megapage must have PPN[0] all zero
  assign mega_misaligned = |wb_dat_i[sv32_pkg::PTE_PPN_LSB +: sv32_pkg::VPN_PART_W];

  // ------------------------------------------------------------------
  // wishbone master
  // ------------------------------------------------------------------
  assign lvl1     = (state_q != mmu_pkg::READ_L0);
  // root table from satp, next table from the pointer entry
  assign base_ppn = lvl1 ? satp_ppn_i : pte_q[sv32_pkg::XLEN_W-1:sv32_pkg::PTE_PPN_LSB];
  assign vpn_part = lvl1 ? vaddr_q[sv32_pkg::VADDR_W-1 -: sv32_pkg::VPN_PART_W] :
                           vaddr_q[sv32_pkg::PAGE_OFFSET_W +: sv32_pkg::VPN_PART_W];
  assign wb_adr_o = {base_ppn, vpn_part, {sv32_pkg::PTE_SIZE_LOG2{1'b0}}};

  // held high through both reads of a 4 KiB walk
  assign wb_cyc_o = (state_q == mmu_pkg::READ_L1) || (state_q == mmu_pkg::READ_L0);
  assign wb_stb_o = wb_cyc_o;

  // ------------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------------
  always_comb begin
    state_d   = state_q;
    mega_d    = mega_q;
    acc_err_d = acc_err_q;
    case (state_q)
      mmu_pkg::IDLE: begin
        if (walk.start) begin
          state_d = mmu_pkg::READ_L1;
        end
      end
      mmu_pkg::READ_L1: begin
        if (wb_err_i) begin
          acc_err_d = 1'b1;
          state_d   = mmu_pkg::FAULT;
        end else if (wb_ack_i) begin
          acc_err_d = 1'b0;
          mega_d    = 1'b1;
          if (pte_inv) begin
            state_d = mmu_pkg::FAULT;
          end else if (pte_leaf) begin
            state_d = mega_misaligned ? mmu_pkg::FAULT : mmu_pkg::UPDATE;
          end else begin
            state_d = mmu_pkg::READ_L0;
          end
        end
      end
      mmu_pkg::READ_L0: begin
        if (wb_err_i) begin
          acc_err_d = 1'b1;
          state_d   = mmu_pkg::FAULT;
        end else if (wb_ack_i) begin
          acc_err_d = 1'b0;
          mega_d    = 1'b0;
          // a pointer at the last level is a fault too
          state_d   = (pte_inv || !pte_leaf) ? mmu_pkg::FAULT : mmu_pkg::UPDATE;
        end
      end
      // UPDATE and FAULT last one cycle
      default: state_d = mmu_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= mmu_pkg::IDLE;
      flushed_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == mmu_pkg::IDLE) begin
        flushed_q <= 1'b0;
      end else if (flush_i) begin
        flushed_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    mega_q    <= mega_d;
    acc_err_q <= acc_err_d;
    if (walk.start) begin
      vaddr_q <= walk.vaddr;
    end
    // keeps the pointer after level 1 and the leaf at the end
    if (wb_cyc_o && wb_ack_i) begin
      pte_q <= wb_dat_i;
    end
  end

  // ------------------------------------------------------------------
  // results
  // ------------------------------------------------------------------
  assign walk.busy         = (state_q != mmu_pkg::IDLE);
  assign walk.page_fault   = (state_q == mmu_pkg::FAULT) && !acc_err_q;
  assign walk.access_fault = (state_q == mmu_pkg::FAULT) && acc_err_q;

  assign upd.valid   = (state_q == mmu_pkg::UPDATE) && !flushed_q && !flush_i;
  assign upd.vpn     = vaddr_q[sv32_pkg::VADDR_W-1:sv32_pkg::PAGE_OFFSET_W];
  assign upd.pte     = pte_q;
  assign upd.is_mega = mega_q;

endmodule

// File: lsu_xlate.sv
// Load/store address translation stage.
// Grants a request on a TLB hit, a walker fault or with translation off,
// then gives the physical address and any exception one cycle later.
`timescale 1ns/1ps

module lsu_xlate (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             en_translation_i,
  input  sv32_pkg::priv_t  priv_i,
  input  logic             sum_i,
  input  logic             mxr_i,
  input  logic             lsu_req_i,
  input  sv32_pkg::vaddr_t lsu_vaddr_i,
  input  logic             lsu_is_store_i,
  output logic             lsu_gnt_o,
  output logic             lsu_valid_o,
  output sv32_pkg::paddr_t lsu_paddr_o,
  output logic             lsu_exc_valid_o,
  output sv32_pkg::cause_t lsu_exc_cause_o,
  output sv32_pkg::vaddr_t lsu_exc_tval_o,
  input  logic             tlb_hit_i,
  input  sv32_pkg::pte_t   tlb_pte_i,
  input  logic             tlb_is_mega_i,
  walk_if.requester        walk
);

  // result stage
  logic             req_q;
  sv32_pkg::vaddr_t vaddr_q;
  logic             store_q;
  logic             xlate_q;
  sv32_pkg::pte_t   pte_q;
  logic             mega_q;
  logic             pf_q;
  logic             af_q;

  logic             perm_err;

  // ------------------------------------------------------------------
  // lookup cycle
  // ------------------------------------------------------------------
  // a walker fault always belongs to the request being held
  assign lsu_gnt_o = lsu_req_i &&
                     (!en_translation_i || tlb_hit_i || walk.page_fault || walk.access_fault);

  // miss with an idle walker starts a walk
  assign walk.start = lsu_req_i && en_translation_i && !tlb_hit_i && !walk.busy;
  assign walk.vaddr = lsu_vaddr_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_q <= 1'b0;
    end else begin
      req_q <= lsu_gnt_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lsu_gnt_o) begin
      vaddr_q <= lsu_vaddr_i;
      store_q <= lsu_is_store_i;
      xlate_q <= en_translation_i;
      pte_q   <= tlb_pte_i;
      mega_q  <= tlb_is_mega_i;
      pf_q    <= walk.page_fault;
      af_q    <= walk.access_fault;
    end
  end

  // ------------------------------------------------------------------
  // result cycle
  // ------------------------------------------------------------------
  always_comb begin
    if (!xlate_q) begin
      // bare mode, zero extended
      lsu_paddr_o = sv32_pkg::paddr_t'(vaddr_q);
    end else if (mega_q) begin
      lsu_paddr_o = {pte_q[sv32_pkg::XLEN_W-1 -: sv32_pkg::PPN_W - sv32_pkg::VPN_PART_W],
                     vaddr_q[sv32_pkg::VPN_PART_W + sv32_pkg::PAGE_OFFSET_W - 1:0]};
    end else begin
      lsu_paddr_o = {pte_q[sv32_pkg::XLEN_W-1:sv32_pkg::PTE_PPN_LSB],
                     vaddr_q[sv32_pkg::PAGE_OFFSET_W-1:0]};
    end
  end

  // permission check on the cached leaf
  always_comb begin
    perm_err = !pte_q[sv32_pkg::PTE_A];
    if (priv_i == sv32_pkg::PRIV_U && !pte_q[sv32_pkg::PTE_U]) begin
      perm_err = 1'b1;
    end
    // supervisor may touch user pages only with SUM
    if (priv_i == sv32_pkg::PRIV_S && pte_q[sv32_pkg::PTE_U] && !sum_i) begin
      perm_err = 1'b1;
    end
    if (store_q) begin
      if (!pte_q[sv32_pkg::PTE_W] || !pte_q[sv32_pkg::PTE_D]) begin
        perm_err = 1'b1;
      end
    end else begin
      // MXR makes executable pages readable
      if (!pte_q[sv32_pkg::PTE_R] && !(pte_q[sv32_pkg::PTE_X] && mxr_i)) begin
        perm_err = 1'b1;
      end
    end
  end

  assign lsu_valid_o     = req_q;
  assign lsu_exc_valid_o = req_q && xlate_q && (pf_q || af_q || perm_err);

  // access faults only come from a bus error during the walk
  always_comb begin
    if (af_q) begin
      lsu_exc_cause_o = store_q ? sv32_pkg::CAUSE_ST_ACCESS : sv32_pkg::CAUSE_LD_ACCESS;
    end else begin
      lsu_exc_cause_o = store_q ? sv32_pkg::CAUSE_ST_PAGE : sv32_pkg::CAUSE_LD_PAGE;
    end
  end

  assign lsu_exc_tval_o = lsu_exc_valid_o ? vaddr_q : '0;

endmodule

// File: mmu_top.sv
// Data side Sv32 MMU top level.
// Connects the data TLB, the page table walker and the load/store
// translation stage, exposes the LSU, control and Wishbone ports.
`timescale 1ns/1ps

module mmu_top (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // control
  input  logic             flush_i,
  input  logic             en_translation_i,
  input  sv32_pkg::priv_t  priv_i,
  input  logic             sum_i,
  input  logic             mxr_i,
  input  sv32_pkg::ppn_t   satp_ppn_i,
  // load/store unit
  input  logic             lsu_req_i,
  input  sv32_pkg::vaddr_t lsu_vaddr_i,
  input  logic             lsu_is_store_i,
  output logic             lsu_gnt_o,
  output logic             lsu_valid_o,
  output sv32_pkg::paddr_t lsu_paddr_o,
  output logic             lsu_exc_valid_o,
  output sv32_pkg::cause_t lsu_exc_cause_o,
  output sv32_pkg::vaddr_t lsu_exc_tval_o,
  // wishbone classic, read only
  output logic             wb_cyc_o,
  output logic             wb_stb_o,
  output sv32_pkg::paddr_t wb_adr_o,
  input  sv32_pkg::pte_t   wb_dat_i,
  input  logic             wb_ack_i,
  input  logic             wb_err_i
);

  tlb_update_if upd_if ();
  walk_if       walk_bus ();

  logic           tlb_hit;
  sv32_pkg::pte_t tlb_pte;
  logic           tlb_is_mega;

  // looked up with the VPN of the incoming request
  dtlb i_dtlb (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .lookup_vpn_i (lsu_vaddr_i[sv32_pkg::VADDR_W-1:sv32_pkg::PAGE_OFFSET_W]),
    .hit_o        (tlb_hit),
    .pte_o        (tlb_pte),
    .is_mega_o    (tlb_is_mega),
    .upd          (upd_if.tlb)
  );

  ptw i_ptw (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .satp_ppn_i (satp_ppn_i),
    .walk       (walk_bus.walker),
    .upd        (upd_if.walker),
    .wb_cyc_o   (wb_cyc_o),
    .wb_stb_o   (wb_stb_o),
    .wb_adr_o   (wb_adr_o),
    .wb_dat_i   (wb_dat_i),
    .wb_ack_i   (wb_ack_i),
    .wb_err_i   (wb_err_i)
  );

  lsu_xlate i_lsu_xlate (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .en_translation_i (en_translation_i),
    .priv_i           (priv_i),
    .sum_i            (sum_i),
    .mxr_i            (mxr_i),
    .lsu_req_i        (lsu_req_i),
    .lsu_vaddr_i      (lsu_vaddr_i),
    .lsu_is_store_i   (lsu_is_store_i),
    .lsu_gnt_o        (lsu_gnt_o),
    .lsu_valid_o      (lsu_valid_o),
    .lsu_paddr_o      (lsu_paddr_o),
    .lsu_exc_valid_o  (lsu_exc_valid_o),
    .lsu_exc_cause_o  (lsu_exc_cause_o),
    .lsu_exc_tval_o   (lsu_exc_tval_o),
    .tlb_hit_i        (tlb_hit),
    .tlb_pte_i        (tlb_pte),
    .tlb_is_mega_i    (tlb_is_mega),
    .walk             (walk_bus.requester)
  );

endmodule

// File: mmu_checker.sv
// Testbench checker for the data MMU.
// Queues every granted request and, one cycle later, compares the DUT
// result with a reference walk of the page tables in tb_mmu.
`timescale 1ns/1ps

module mmu_checker #(
  parameter sv32_pkg::paddr_t ERR_LO = 34'h3000
) (
  input logic             clk_i,
  input logic             rst_n_i,
  input logic             en_translation_i,
  input sv32_pkg::priv_t  priv_i,
  input logic             sum_i,
  input logic             mxr_i,
  input sv32_pkg::ppn_t   satp_ppn_i,
  input sv32_pkg::vaddr_t lsu_vaddr_i,
  input logic             lsu_is_store_i,
  input logic             lsu_gnt_i,
  input logic             lsu_valid_i,
  input sv32_pkg::paddr_t lsu_paddr_i,
  input logic             lsu_exc_valid_i,
  input sv32_pkg::cause_t lsu_exc_cause_i,
  input sv32_pkg::vaddr_t lsu_exc_tval_i
);

  typedef struct packed {
    sv32_pkg::vaddr_t va;
    logic             st;
    logic             en;
  } req_t;

  typedef struct packed {
    sv32_pkg::paddr_t paddr;
    logic             exc;
    sv32_pkg::cause_t cause;
    sv32_pkg::vaddr_t tval;
  } result_t;

  req_t    pend_q [$];
  req_t    cur_req;
  result_t cur_exp;
  int      n_checks = 0;
  int      n_errors = 0;

  task automatic check_value(input string what, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    n_checks++;
    if (exp_v !== act_v) begin
      n_errors++;
      $display("[ERROR] %s %s expected %h actual %h", tb_mmu.test_name, what, exp_v, act_v);
    end
  endtask

  // ------------------------------------------------------------------
  // reference translation
  // ------------------------------------------------------------------
  function automatic result_t ref_xlate(input sv32_pkg::vaddr_t va, input logic st,
                                        input logic en);
    result_t          r;
    sv32_pkg::paddr_t adr;
    sv32_pkg::pte_t   pte;
    logic             mega;
    logic             done;
    logic             pf;
    logic             af;
    r    = '0;
    pte  = '0;
    mega = 1'b0;
    done = 1'b0;
    pf   = 1'b0;
    af   = 1'b0;
    if (!en) begin
      r.paddr = {2'b00, va};
      return r;
    end
    // level 1 entry
    adr = {satp_ppn_i, va[31:22], 2'b00};
    if (adr >= ERR_LO) begin
      af   = 1'b1;
      done = 1'b1;
    end else begin
      pte = tb_mmu.pt_mem[adr[13:2]];
      if (!pte[sv32_pkg::PTE_V] || (pte[sv32_pkg::PTE_W] && !pte[sv32_pkg::PTE_R])) begin
        pf   = 1'b1;
        done = 1'b1;
      end else if (pte[sv32_pkg::PTE_R] || pte[sv32_pkg::PTE_X]) begin
        // megapage leaf needs PPN[0] zero
        mega = 1'b1;
        done = 1'b1;
        pf   = (pte[19:10] != '0);
      end
    end
    // level 0 entry, must be a valid leaf
    if (!done) begin
      adr = {pte[31:10], va[21:12], 2'b00};
      if (adr >= ERR_LO) begin
        af = 1'b1;
      end else begin
        pte = tb_mmu.pt_mem[adr[13:2]];
        pf  = !pte[sv32_pkg::PTE_V] || (pte[sv32_pkg::PTE_W] && !pte[sv32_pkg::PTE_R]) ||
              !(pte[sv32_pkg::PTE_R] || pte[sv32_pkg::PTE_X]);
      end
    end
    // permission rules on the leaf
    if (!pf && !af) begin
      pf = !pte[sv32_pkg::PTE_A] ||
           (priv_i == sv32_pkg::PRIV_U && !pte[sv32_pkg::PTE_U]) ||
           (priv_i == sv32_pkg::PRIV_S && pte[sv32_pkg::PTE_U] && !sum_i);
      if (st) begin
        pf = pf || !pte[sv32_pkg::PTE_W] || !pte[sv32_pkg::PTE_D];
      end else begin
        pf = pf || (!pte[sv32_pkg::PTE_R] && !(pte[sv32_pkg::PTE_X] && mxr_i));
      end
      r.paddr = mega ? {pte[31:20], va[21:0]} : {pte[31:10], va[11:0]};
    end
    r.exc = pf || af;
    if (af) begin
      r.cause = st ? sv32_pkg::CAUSE_ST_ACCESS : sv32_pkg::CAUSE_LD_ACCESS;
    end else begin
      r.cause = st ? sv32_pkg::CAUSE_ST_PAGE : sv32_pkg::CAUSE_LD_PAGE;
    end
    r.tval = r.exc ? va : '0;
    return r;
  endfunction

  // ------------------------------------------------------------------
  // compare
  // ------------------------------------------------------------------
  // a result is due exactly one cycle after each grant
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q.delete();
    end else begin
      if (pend_q.size() != 0) begin
        cur_req = pend_q.pop_front();
        if (!lsu_valid_i) begin
          n_errors++;
          $display("%s: no result one cycle after the grant of vaddr %h",
                   tb_mmu.test_name, cur_req.va);
        end else begin
          cur_exp = ref_xlate(cur_req.va, cur_req.st, cur_req.en);
          check_value("exc_valid", cur_exp.exc, lsu_exc_valid_i);
          check_value("tval", cur_exp.tval, lsu_exc_tval_i);
          if (cur_exp.exc) begin
            check_value("cause", cur_exp.cause, lsu_exc_cause_i);
          end else begin
            check_value("paddr", cur_exp.paddr, lsu_paddr_i);
          end
        end
      end else if (lsu_valid_i) begin
        n_errors++;
        $display("%s: result seen without a granted request", tb_mmu.test_name);
      end
      if (lsu_gnt_i) begin
        pend_q.push_back({lsu_vaddr_i, lsu_is_store_i, en_translation_i});
      end
    end
  end

endmodule

// File: tb_mmu.sv
// Testbench top for the data side Sv32 MMU.
// Drives clock, reset and LSU requests, models a Wishbone page table
// memory with a random ack delay and hooks up the checker.
`timescale 1ns/1ps

module tb_mmu;

  // addresses from here on answer with err
  localparam sv32_pkg::paddr_t ERR_LO = 34'h3000;
  localparam int MEM_WORDS   = 3072;
  localparam int GNT_TIMEOUT = 200;

  logic             clk, rst_n, flush;
  logic             en_xlate, sum, mxr;
  sv32_pkg::priv_t  priv;
  sv32_pkg::ppn_t   satp_ppn;
  logic             req, is_store, gnt, valid, exc_valid;
  sv32_pkg::vaddr_t vaddr, exc_tval;
  sv32_pkg::paddr_t paddr, wb_adr;
  sv32_pkg::cause_t exc_cause;
  logic             wb_cyc, wb_stb, wb_ack, wb_err;
  sv32_pkg::pte_t   wb_dat;

  sv32_pkg::pte_t   pt_mem [MEM_WORDS];
  string            test_name;
  integer           seed;
  int               wait_left;
  logic             in_cycle;
  int               wb_reads;
  int               n_tests, last_checks, last_errors;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  mmu_top uut (
    .clk_i (clk), .rst_n_i (rst_n), .flush_i (flush), .en_translation_i (en_xlate),
    .priv_i (priv), .sum_i (sum), .mxr_i (mxr), .satp_ppn_i (satp_ppn),
    .lsu_req_i (req), .lsu_vaddr_i (vaddr), .lsu_is_store_i (is_store),
    .lsu_gnt_o (gnt), .lsu_valid_o (valid), .lsu_paddr_o (paddr),
    .lsu_exc_valid_o (exc_valid), .lsu_exc_cause_o (exc_cause), .lsu_exc_tval_o (exc_tval),
    .wb_cyc_o (wb_cyc), .wb_stb_o (wb_stb), .wb_adr_o (wb_adr),
    .wb_dat_i (wb_dat), .wb_ack_i (wb_ack), .wb_err_i (wb_err)
  );

  mmu_checker #(.ERR_LO(ERR_LO)) chk (
    .clk_i (clk), .rst_n_i (rst_n), .en_translation_i (en_xlate),
    .priv_i (priv), .sum_i (sum), .mxr_i (mxr), .satp_ppn_i (satp_ppn),
    .lsu_vaddr_i (vaddr), .lsu_is_store_i (is_store), .lsu_gnt_i (gnt),
    .lsu_valid_i (valid), .lsu_paddr_i (paddr), .lsu_exc_valid_i (exc_valid),
    .lsu_exc_cause_i (exc_cause), .lsu_exc_tval_i (exc_tval)
  );

  // ------------------------------------------------------------------
  // wishbone page table memory
  // ------------------------------------------------------------------
  // answers on the falling edge after 0 to 3 idle cycles
  always @(negedge clk) begin
    // classic bus, stb rises and falls together with cyc
    if (rst_n && (wb_cyc || wb_stb)) begin
      chk.check_value("wb_stb", wb_cyc, wb_stb);
    end
    if (!rst_n || wb_ack || wb_err) begin
      wb_ack   = 1'b0;
      wb_err   = 1'b0;
      in_cycle = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!in_cycle) begin
        in_cycle  = 1'b1;
        wait_left = $unsigned($random(seed)) % 4;
      end
      if (wait_left == 0) begin
        wb_err = (wb_adr >= ERR_LO);
        wb_ack = !wb_err;
        wb_dat = wb_err ? '0 : pt_mem[wb_adr[13:2]];
      end else begin
        wait_left--;
      end
    end
  end

  // completed bus reads, used to see whether a walk happened
  always @(posedge clk) begin
    if (rst_n && wb_cyc && (wb_ack || wb_err)) begin
      wb_reads++;
    end
  end

  function automatic sv32_pkg::pte_t mk_pte(input sv32_pkg::ppn_t ppn, input logic [7:0] flags);
    return {ppn, 2'b00, flags};
  endfunction

  // root table at 0x1000 (satp ppn 1), leaf table at 0x2000
  task automatic build_tables();
    for (int i = 0; i < MEM_WORDS; i++) begin
      // V clear, so unused words are invalid entries
      pt_mem[i] = {i[23:0], 8'hE0};
    end
    pt_mem[12'h401] = mk_pte(22'h2, 8'h01);
    pt_mem[12'h402] = mk_pte({12'h0AB, 10'h0}, 8'hC7);
    pt_mem[12'h403] = '0;
    // megapage with PPN[0] nonzero
    pt_mem[12'h404] = mk_pte(22'h0AC05, 8'hC7);
    pt_mem[12'h405] = mk_pte(22'h2, 8'h01);
    // next table lies in the err range
    pt_mem[12'h406] = mk_pte(22'h3, 8'h01);
    pt_mem[12'h801] = mk_pte(22'h12345, 8'hC7);
    pt_mem[12'h802] = mk_pte(22'h01002, 8'hD7);
    pt_mem[12'h803] = mk_pte(22'h01003, 8'hC3);
    pt_mem[12'h804] = mk_pte(22'h01004, 8'h47);
    pt_mem[12'h805] = mk_pte(22'h01005, 8'hC9);
    pt_mem[12'h806] = mk_pte(22'h01006, 8'h87);
    // pointer at level 0
    pt_mem[12'h807] = mk_pte(22'h3, 8'h01);
    for (int i = 8; i < 14; i++) begin
      pt_mem[12'h800 + i] = mk_pte(22'h100 + i, 8'hC7);
    end
  endtask

  // ------------------------------------------------------------------
  // stimulus tasks
  // ------------------------------------------------------------------
  // returns after the posedge that took the grant
  task automatic access(input sv32_pkg::vaddr_t va, input logic st, output int waits);
    @(negedge clk);
    req      = 1'b1;
    vaddr    = va;
    is_store = st;
    waits    = 0;
    @(posedge clk);
    while (!gnt && waits < GNT_TIMEOUT) begin
      waits++;
      @(posedge clk);
    end
    if (!gnt) begin
      $display("timeout in test %s: no grant for vaddr %h", test_name, va);
      $display("Finished with errors");
      $finish;
    end
  endtask

  // the last result shows one cycle after its grant
  task automatic idle();
    @(negedge clk);
    req = 1'b0;
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic set_mode(input logic en, input sv32_pkg::priv_t p, input logic s,
                          input logic m);
    idle();
    en_xlate = en;
    priv     = p;
    sum      = s;
    mxr      = m;
  endtask

  task automatic do_flush();
    @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    last_checks = chk.n_checks;
    last_errors = chk.n_errors;
  endtask

  task automatic end_test();
    idle();
    n_tests++;
    $display("test %s done: %0d checks, %0d errors", test_name,
             chk.n_checks - last_checks, chk.n_errors - last_errors);
  endtask

  // ------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------
  initial begin : stimulus
    int w;
    int r0;
    rst_n = 1'b0;
    flush = 1'b0;
    en_xlate = 1'b0;
    priv = sv32_pkg::PRIV_S;
    sum = 1'b0;
    mxr = 1'b0;
    satp_ppn = 22'h1;
    req = 1'b0;
    vaddr = '0;
    is_store = 1'b0;
    wb_ack = 1'b0;
    wb_err = 1'b0;
    wb_dat = '0;
    seed = 12;
    in_cycle = 1'b0;
    wait_left = 0;
    wb_reads = 0;
    n_tests = 0;
    test_name = "reset";
    build_tables();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // bare mode, grant in the request cycle
    start_test("bare");
    access(32'h8000_1234, 1'b0, w);
    chk.check_value("grant delay", 0, w);
    access(32'h1234_5678, 1'b1, w);
    chk.check_value("grant delay", 0, w);
    end_test();

    start_test("walk_and_hit");
    set_mode(1'b1, sv32_pkg::PRIV_S, 1'b0, 1'b0);
    r0 = wb_reads;
    access(32'h0040_1ABC, 1'b0, w);
    idle();
    chk.check_value("walk reads 4k", 2, wb_reads - r0);
    r0 = wb_reads;
    access(32'h0081_2345, 1'b1, w);
    idle();
    chk.check_value("walk reads mega", 1, wb_reads - r0);
    // back to back hits on both pages
    for (int i = 0; i < 4; i++) begin
      access(32'h0040_1000 + i * 4, 1'b0, w);
      chk.check_value("hit grant delay", 0, w);
      access(32'h0083_0000 + i * 8, 1'b1, w);
      chk.check_value("hit grant delay", 0, w);
    end
    end_test();

    start_test("permissions");
    set_mode(1'b1, sv32_pkg::PRIV_U, 1'b0, 1'b0);
    access(32'h0040_2010, 1'b0, w);
    access(32'h0040_1010, 1'b0, w);
    set_mode(1'b1, sv32_pkg::PRIV_S, 1'b0, 1'b0);
    access(32'h0040_2020, 1'b1, w);
    set_mode(1'b1, sv32_pkg::PRIV_S, 1'b1, 1'b0);
    access(32'h0040_2020, 1'b1, w);
    access(32'h0040_3000, 1'b1, w);
    access(32'h0040_3004, 1'b0, w);
    access(32'h0040_4008, 1'b1, w);
    access(32'h0040_5000, 1'b0, w);
    set_mode(1'b1, sv32_pkg::PRIV_S, 1'b1, 1'b1);
    access(32'h0040_5010, 1'b0, w);
    access(32'h0040_6000, 1'b0, w);
    end_test();

    start_test("walk_faults");
    set_mode(1'b1, sv32_pkg::PRIV_S, 1'b0, 1'b0);
    access(32'h00C0_0000, 1'b0, w);
    access(32'h00C0_0100, 1'b1, w);
    access(32'h0100_0000, 1'b0, w);
    access(32'h0140_7000, 1'b1, w);
    access(32'h0180_0040, 1'b0, w);
    access(32'h0180_0080, 1'b1, w);
    end_test();

    start_test("flush");
    access(32'h0040_1ABC, 1'b0, w);
    idle();
    r0 = wb_reads;
    access(32'h0040_1AC0, 1'b0, w);
    idle();
    chk.check_value("reads on hit", 0, wb_reads - r0);
    pt_mem[12'h801] = mk_pte(22'h23456, 8'hC7);
    do_flush();
    r0 = wb_reads;
    access(32'h0040_1AC4, 1'b0, w);
    idle();
    chk.check_value("reads after flush", 2, wb_reads - r0);
    end_test();

    // six pages rotate through four entries
    start_test("round_robin");
    for (int n = 0; n < 2; n++) begin
      for (int i = 8; i < 14; i++) begin
        access(32'h0040_0000 | (i << 12) | ($random(seed) & 32'hFFC), n[0], w);
      end
    end
    end_test();

    $display("tests: %0d, checks: %0d, errors: %0d", n_tests, chk.n_checks, chk.n_errors);
    if (chk.n_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: sources.f
sv32_pkg.sv
mmu_pkg.sv
tlb_update_if.sv
walk_if.sv
dtlb.sv
ptw.sv
lsu_xlate.sv
mmu_top.sv
mmu_checker.sv
tb_mmu.sv

// File: Bender.yml
package:
  name: sv32_dmmu

sources:
  - sv32_pkg.sv
  - mmu_pkg.sv
  - tlb_update_if.sv
  - walk_if.sv
  - dtlb.sv
  - ptw.sv
  - lsu_xlate.sv
  - mmu_top.sv
  - target: test
    files:
      - mmu_checker.sv
      - tb_mmu.sv
